//--- src/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Instruction word and PC
`define INSTR_W 32

// Architectural register index
`define REG_IDX_W 5

// ALU immediate, wide enough for LU12I.W si20
`define ALU_IMM_W 20

// Branch immediate, wide enough for B/BL offs26
`define BRU_IMM_W 26

// Exception code raised before decode
`define EXC_W 2

`endif

//--- src/decode_pkg.sv
`default_nettype none

`include "decode_defines.svh"

package decode_pkg;

    typedef logic [`INSTR_W-1:0]   instr_t;
    typedef logic [`INSTR_W-1:0]   pc_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`ALU_IMM_W-1:0] alu_imm_t;
    typedef logic [`BRU_IMM_W-1:0] bru_imm_t;
    typedef logic [`EXC_W-1:0]     exc_t;      // Zero means no exception
    typedef logic [`EXC_W:0]       exc3_t;     // MSB is illegal instruction

    typedef enum logic [2:0] {
        IQ_NONE   = 3'b000,
        IQ_BRU    = 3'b001,
        IQ_MULDIV = 3'b010,
        IQ_ALU    = 3'b100
    } iq_sel_t;

    // Codes follow the existing ALU encoding, gaps are the dropped counter reads
    typedef enum logic [4:0] {
        ALU_LU12I = 5'd0,
        ALU_SLTI  = 5'd1,
        ALU_SLTUI = 5'd2,
        ALU_ADDI  = 5'd3,
        ALU_ANDI  = 5'd4,
        ALU_ORI   = 5'd5,
        ALU_XORI  = 5'd6,
        ALU_ADD   = 5'd7,
        ALU_SUB   = 5'd8,
        ALU_SLT   = 5'd9,
        ALU_SLTU  = 5'd10,
        ALU_NOR   = 5'd11,
        ALU_AND   = 5'd12,
        ALU_OR    = 5'd13,
        ALU_XOR   = 5'd14,
        ALU_SLL   = 5'd15,
        ALU_SRL   = 5'd16,
        ALU_SRA   = 5'd17,
        ALU_SLLI  = 5'd21,
        ALU_SRLI  = 5'd22,
        ALU_SRAI  = 5'd23
    } alu_op_t;

    typedef enum logic [2:0] {
        MD_DIV   = 3'd0,
        MD_MOD   = 3'd1,
        MD_DIVU  = 3'd2,
        MD_MODU  = 3'd3,
        MD_MUL   = 3'd4,
        MD_MULH  = 3'd5,
        MD_MULHU = 3'd6
    } muldiv_op_t;

    typedef enum logic [3:0] {
        BRU_PCADDU12I = 4'd0,
        BRU_JIRL      = 4'd1,
        BRU_B         = 4'd2,
        BRU_BL        = 4'd3,
        BRU_BEQ       = 4'd4,
        BRU_BNE       = 4'd5,
        BRU_BLT       = 4'd6,
        BRU_BGE       = 4'd7,
        BRU_BLTU      = 4'd8,
        BRU_BGEU      = 4'd9
    } bru_op_t;

    typedef struct packed {
        alu_op_t    alu_op;
        muldiv_op_t muldiv_op;
        alu_imm_t   alu_imm;
    } exec_fields_t;

    typedef struct packed {
        bru_op_t  bru_op;
        bru_imm_t bru_imm;
    } branch_fields_t;

    typedef struct packed {
        logic     dest_en;
        reg_idx_t dest;
        logic     src1_en;
        reg_idx_t src1;
        logic     src2_en;
        reg_idx_t src2;
    } operand_fields_t;

    typedef struct packed {
        iq_sel_t         iq_sel;
        exec_fields_t    exec;
        branch_fields_t  branch;
        operand_fields_t operands;
    } uop_t;

endpackage

`default_nettype wire

//--- src/queue_select.sv
`default_nettype none

module queue_select (
    input  decode_pkg::instr_t  instr,
    output decode_pkg::iq_sel_t iq_sel
);

    logic is_alu_3r;
    logic is_shift_imm;
    logic is_alu_2ri12;
    logic is_lu12i;
    logic is_pcaddu;
    logic is_muldiv;
    logic is_branch;

    // ADD SUB SLT SLTU NOR AND OR XOR SLL SRL SRA
    assign is_alu_3r = instr[31:15] inside {
        17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028, 17'h00029,
        17'h0002a, 17'h0002b, 17'h0002e, 17'h0002f, 17'h00030
    };

    assign is_shift_imm = instr[31:15] inside {17'h00081, 17'h00089, 17'h00091};

    // SLTI SLTUI ADDI ANDI ORI XORI
    assign is_alu_2ri12 = instr[31:22] inside {
        10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f
    };

    assign is_lu12i  = instr[31:25] == 7'b0001010;
    assign is_pcaddu = instr[31:25] == 7'b0001110;

    // MUL MULH MULHU, then DIV MOD DIVU MODU
    assign is_muldiv = instr[31:15] inside {
        17'h00038, 17'h00039, 17'h0003a,
        17'h00040, 17'h00041, 17'h00042, 17'h00043
    };

    // JIRL through BGEU
    assign is_branch = (instr[31:26] >= 6'h13) && (instr[31:26] <= 6'h1b);

    always_comb begin
        if (is_alu_3r || is_shift_imm || is_alu_2ri12 || is_lu12i) begin
            iq_sel = decode_pkg::IQ_ALU;
        end else if (is_muldiv) begin
            iq_sel = decode_pkg::IQ_MULDIV;
        end else if (is_pcaddu || is_branch) begin
            iq_sel = decode_pkg::IQ_BRU;
        end else begin
            iq_sel = decode_pkg::IQ_NONE; // Illegal instruction
        end
    end

endmodule

`default_nettype wire

//--- src/exec_decode.sv
`default_nettype none

module exec_decode (
    input  decode_pkg::instr_t       instr,
    input  decode_pkg::iq_sel_t      iq_sel,
    output decode_pkg::exec_fields_t exec
);

    always_comb begin
        exec = '0;
        case (iq_sel)
            decode_pkg::IQ_ALU: begin
                if (instr[28]) begin // LU12I.W
                    exec.alu_op  = decode_pkg::ALU_LU12I;
                    exec.alu_imm = instr[24:5];
                end else begin
                    exec.alu_imm = decode_pkg::alu_imm_t'(instr[21:10]);
                    if (instr[25]) begin // 2RI12 group
                        case (instr[24:22])
                            3'b000:  exec.alu_op = decode_pkg::ALU_SLTI;
                            3'b001:  exec.alu_op = decode_pkg::ALU_SLTUI;
                            3'b010:  exec.alu_op = decode_pkg::ALU_ADDI;
                            3'b101:  exec.alu_op = decode_pkg::ALU_ANDI;
                            3'b110:  exec.alu_op = decode_pkg::ALU_ORI;
                            3'b111:  exec.alu_op = decode_pkg::ALU_XORI;
                            default: ;
                        endcase
                    end else begin
                        // Bit 22 splits shift-immediates from 3R ops
                        case (instr[22:15])
                            8'h20:   exec.alu_op = decode_pkg::ALU_ADD;
                            8'h22:   exec.alu_op = decode_pkg::ALU_SUB;
                            8'h24:   exec.alu_op = decode_pkg::ALU_SLT;
                            8'h25:   exec.alu_op = decode_pkg::ALU_SLTU;
                            8'h28:   exec.alu_op = decode_pkg::ALU_NOR;
                            8'h29:   exec.alu_op = decode_pkg::ALU_AND;
                            8'h2a:   exec.alu_op = decode_pkg::ALU_OR;
                            8'h2b:   exec.alu_op = decode_pkg::ALU_XOR;
                            8'h2e:   exec.alu_op = decode_pkg::ALU_SLL;
                            8'h2f:   exec.alu_op = decode_pkg::ALU_SRL;
                            8'h30:   exec.alu_op = decode_pkg::ALU_SRA;
                            8'h81:   exec.alu_op = decode_pkg::ALU_SLLI;
                            8'h89:   exec.alu_op = decode_pkg::ALU_SRLI;
                            8'h91:   exec.alu_op = decode_pkg::ALU_SRAI;
                            default: ;
                        endcase
                    end
                end
            end
            decode_pkg::IQ_MULDIV: begin
                case ({instr[21], instr[16:15]}) // Bit 21 set for divide group
                    3'b000:  exec.muldiv_op = decode_pkg::MD_MUL;
                    3'b001:  exec.muldiv_op = decode_pkg::MD_MULH;
                    3'b010:  exec.muldiv_op = decode_pkg::MD_MULHU;
                    3'b100:  exec.muldiv_op = decode_pkg::MD_DIV;
                    3'b101:  exec.muldiv_op = decode_pkg::MD_MOD;
                    3'b110:  exec.muldiv_op = decode_pkg::MD_DIVU;
                    3'b111:  exec.muldiv_op = decode_pkg::MD_MODU;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src/branch_decode.sv
`default_nettype none

module branch_decode (
    input  decode_pkg::instr_t         instr,
    input  decode_pkg::iq_sel_t        iq_sel,
    output decode_pkg::branch_fields_t branch
);

    always_comb begin
        branch = '0;
        if (iq_sel == decode_pkg::IQ_BRU) begin
            if (!instr[30]) begin // PCADDU12I
                branch.bru_op  = decode_pkg::BRU_PCADDU12I;
                branch.bru_imm = decode_pkg::bru_imm_t'(instr[24:5]);
            end else begin
                if (instr[29:27] == 3'b010) begin
                    branch.bru_imm = {instr[9:0], instr[25:10]}; // offs26 of B and BL
                end else begin
                    branch.bru_imm = decode_pkg::bru_imm_t'(instr[25:10]);
                end
                case (instr[29:26])
                    4'h3:    branch.bru_op = decode_pkg::BRU_JIRL;
                    4'h4:    branch.bru_op = decode_pkg::BRU_B;
                    4'h5:    branch.bru_op = decode_pkg::BRU_BL;
                    4'h6:    branch.bru_op = decode_pkg::BRU_BEQ;
                    4'h7:    branch.bru_op = decode_pkg::BRU_BNE;
                    4'h8:    branch.bru_op = decode_pkg::BRU_BLT;
                    4'h9:    branch.bru_op = decode_pkg::BRU_BGE;
                    4'ha:    branch.bru_op = decode_pkg::BRU_BLTU;
                    4'hb:    branch.bru_op = decode_pkg::BRU_BGEU;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/operand_decode.sv
`default_nettype none

module operand_decode (
    input  decode_pkg::instr_t          instr,
    input  decode_pkg::iq_sel_t         iq_sel,
    output decode_pkg::operand_fields_t operands
);

    logic is_jirl;
    logic is_b;
    logic is_bl;
    logic is_cond_br;
    logic is_lu12i;
    logic is_pcaddu;
    logic is_alu_3r;

    assign is_jirl    = instr[31:26] == 6'h13;
    assign is_b       = instr[31:26] == 6'h14;
    assign is_bl      = instr[31:26] == 6'h15;
    assign is_cond_br = (instr[31:26] >= 6'h16) && (instr[31:26] <= 6'h1b); // BEQ to BGEU
    assign is_lu12i   = instr[31:25] == 7'b0001010;
    assign is_pcaddu  = instr[31:25] == 7'b0001110;
    assign is_alu_3r  = (iq_sel == decode_pkg::IQ_ALU) && (instr[31:20] == 12'h001);

    always_comb begin
        operands = '0;
        if (iq_sel != decode_pkg::IQ_NONE) begin
            operands.dest    = is_bl ? 5'd1 : instr[4:0]; // BL links to r1
            operands.dest_en = (iq_sel != decode_pkg::IQ_BRU) || is_jirl || is_bl || is_pcaddu;
            operands.src1    = instr[9:5];
            operands.src1_en = !(is_lu12i || is_pcaddu || is_b || is_bl);
            if (is_alu_3r || (iq_sel == decode_pkg::IQ_MULDIV)) begin
                operands.src2    = instr[14:10];
                operands.src2_en = 1'b1;
            end else if (is_cond_br) begin
                operands.src2    = instr[4:0]; // rd field is compared, not written
                operands.src2_en = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/decode_stage_reg.sv
`default_nettype none

module decode_stage_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                hold,
    input  logic                instr_vld,
    input  decode_pkg::pc_t     pc_stage2,
    input  decode_pkg::exc_t    except_stage2,
    input  decode_pkg::uop_t    uop_next,
    output logic                decode_vld,
    output decode_pkg::uop_t    uop,
    output decode_pkg::pc_t     pc_stage3,
    output decode_pkg::exc3_t   except_stage3
);

    logic legal;

    assign legal = uop_next.iq_sel != decode_pkg::IQ_NONE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_vld    <= 1'b0;
            uop           <= '0;
            except_stage3 <= '0;
        end else if (flush) begin
            decode_vld    <= 1'b0;
            uop           <= '0;
            except_stage3 <= '0;
        end else if (!hold) begin
            if (|except_stage2) begin // Upstream fault wins over decode
                decode_vld    <= 1'b0;
                uop           <= '0;
                except_stage3 <= {1'b0, except_stage2};
            end else if (instr_vld) begin
                decode_vld    <= legal;
                uop           <= legal ? uop_next : '0;
                except_stage3 <= {~legal, decode_pkg::exc_t'(0)};
            end else begin
                decode_vld    <= 1'b0;
                uop           <= '0;
                except_stage3 <= '0;
            end
        end
    end

    // PC survives flush so the faulting address stays visible
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_stage3 <= '0;
        end else if (!flush && !hold && (instr_vld || (|except_stage2))) begin
            pc_stage3 <= pc_stage2;
        end
    end

endmodule

`default_nettype wire

//--- src/decode_top.sv
`default_nettype none

module decode_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                hold,
    input  logic                instr_vld,
    input  decode_pkg::instr_t  instr,
    input  decode_pkg::pc_t     pc_stage2,
    input  decode_pkg::exc_t    except_stage2,
    output logic                decode_vld,
    output decode_pkg::uop_t    uop,
    output decode_pkg::pc_t     pc_stage3,
    output decode_pkg::exc3_t   except_stage3
);

    wire decode_pkg::uop_t uop_next; // Each decoder drives its own member

    queue_select queue_select_i (
        .instr  (instr),
        .iq_sel (uop_next.iq_sel)
    );

    exec_decode exec_decode_i (
        .instr  (instr),
        .iq_sel (uop_next.iq_sel),
        .exec   (uop_next.exec)
    );

    branch_decode branch_decode_i (
        .instr  (instr),
        .iq_sel (uop_next.iq_sel),
        .branch (uop_next.branch)
    );

    operand_decode operand_decode_i (
        .instr    (instr),
        .iq_sel   (uop_next.iq_sel),
        .operands (uop_next.operands)
    );

    decode_stage_reg decode_stage_reg_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .hold          (hold),
        .instr_vld     (instr_vld),
        .pc_stage2     (pc_stage2),
        .except_stage2 (except_stage2),
        .uop_next      (uop_next),
        .decode_vld    (decode_vld),
        .uop           (uop),
        .pc_stage3     (pc_stage3),
        .except_stage3 (except_stage3)
    );

endmodule

`default_nettype wire

//--- verification/decode_checker.sv
`default_nettype none

module decode_checker (
    input logic              clk,
    input logic              rst_n,
    input logic              flush,
    input logic              hold,
    input logic              decode_vld,
    input decode_pkg::uop_t  uop,
    input decode_pkg::pc_t   pc_stage3,
    input decode_pkg::exc3_t except_stage3
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned assert_failures = 0; // Read by the testbench at the end

    reset_clears_valid: assert property (@(posedge clk) $rose(rst_n) |-> !decode_vld)
        else begin
            assert_failures++;
            $error("decode_vld high on the first edge after reset");
        end

    valid_has_one_queue: assert property (@(posedge clk) disable iff (!rst_n)
        decode_vld |-> $onehot(uop.iq_sel))
        else begin
            assert_failures++;
            $error("decode_vld high without exactly one iq_sel bit");
        end

    // Flush outranks hold, so only hold without flush must freeze the stage
    hold_keeps_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        hold && !flush |=> $stable(decode_vld) && $stable(uop)
                           && $stable(pc_stage3) && $stable(except_stage3))
        else begin
            assert_failures++;
            $error("Outputs changed while hold was high");
        end

    flush_drops_valid: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !decode_vld)
        else begin
            assert_failures++;
            $error("decode_vld high after a flush");
        end

endmodule

`default_nettype wire

//--- verification/decode_tb.sv
`default_nettype none

module decode_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic               clk;
    logic               rst_n;
    logic               flush;
    logic               hold;
    logic               instr_vld;
    decode_pkg::instr_t instr;
    decode_pkg::pc_t    pc_stage2;
    decode_pkg::exc_t   except_stage2;
    logic               decode_vld;
    decode_pkg::uop_t   uop;
    decode_pkg::pc_t    pc_stage3;
    decode_pkg::exc3_t  except_stage3;

    integer          seed;
    integer          errors;
    integer          checks;
    integer          timeouts;
    decode_pkg::pc_t pc_next;

    decode_top decode_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .hold          (hold),
        .instr_vld     (instr_vld),
        .instr         (instr),
        .pc_stage2     (pc_stage2),
        .except_stage2 (except_stage2),
        .decode_vld    (decode_vld),
        .uop           (uop),
        .pc_stage3     (pc_stage3),
        .except_stage3 (except_stage3)
    );

    bind decode_top decode_checker decode_checker_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .hold          (hold),
        .decode_vld    (decode_vld),
        .uop           (uop),
        .pc_stage3     (pc_stage3),
        .except_stage3 (except_stage3)
    );

    always #50 clk = ~clk;

    function automatic decode_pkg::reg_idx_t rand_reg();
        return decode_pkg::reg_idx_t'($random(seed));
    endfunction

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    // Drive on a rising edge, then sample mid-cycle after the DUT has loaded
    task automatic apply(input logic vld, input decode_pkg::instr_t word,
                         input decode_pkg::pc_t pc, input decode_pkg::exc_t exc,
                         input logic hold_v, input logic flush_v);
        @(posedge clk);
        instr_vld     <= vld;
        instr         <= word;
        pc_stage2     <= pc;
        except_stage2 <= exc;
        hold          <= hold_v;
        flush         <= flush_v;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic expect_outputs(input logic vld_exp, input decode_pkg::uop_t exp,
                                  input decode_pkg::pc_t pc_exp,
                                  input decode_pkg::exc3_t exc_exp);
        compare_value("decode_vld", 64'(decode_vld), 64'(vld_exp));
        compare_value("uop.iq_sel", 64'(uop.iq_sel), 64'(exp.iq_sel));
        compare_value("uop.exec", 64'(uop.exec), 64'(exp.exec));
        compare_value("uop.branch", 64'(uop.branch), 64'(exp.branch));
        compare_value("uop.operands", 64'(uop.operands), 64'(exp.operands));
        compare_value("pc_stage3", 64'(pc_stage3), 64'(pc_exp));
        compare_value("except_stage3", 64'(except_stage3), 64'(exc_exp));
    endtask

    task automatic issue_and_check(input decode_pkg::instr_t word, input logic vld_exp,
                                   input decode_pkg::uop_t exp,
                                   input decode_pkg::exc3_t exc_exp);
        decode_pkg::pc_t cur_pc;
        cur_pc  = pc_next;
        pc_next = pc_next + 32'd4;
        apply(1'b1, word, cur_pc, '0, 1'b0, 1'b0);
        expect_outputs(vld_exp, exp, cur_pc, exc_exp);
    endtask

    function automatic decode_pkg::uop_t reg3_uop(input decode_pkg::reg_idx_t rd,
                                                  input decode_pkg::reg_idx_t rj,
                                                  input decode_pkg::reg_idx_t rk,
                                                  input logic rk_is_src);
        decode_pkg::uop_t exp;
        exp                   = '0;
        exp.operands.dest_en  = 1'b1;
        exp.operands.dest     = rd;
        exp.operands.src1_en  = 1'b1;
        exp.operands.src1     = rj;
        exp.operands.src2_en  = rk_is_src;
        exp.operands.src2     = rk_is_src ? rk : '0; // Shift amount is no register
        return exp;
    endfunction

    task automatic alu_reg_case(input logic [16:0] opc, input decode_pkg::alu_op_t op,
                                input logic rk_is_src);
        decode_pkg::reg_idx_t rd;
        decode_pkg::reg_idx_t rj;
        decode_pkg::reg_idx_t rk;
        decode_pkg::instr_t   word;
        decode_pkg::uop_t     exp;
        rd   = rand_reg();
        rj   = rand_reg();
        rk   = rand_reg();
        word = {opc, rk, rj, rd};
        exp  = reg3_uop(rd, rj, rk, rk_is_src);
        exp.iq_sel       = decode_pkg::IQ_ALU;
        exp.exec.alu_op  = op;
        exp.exec.alu_imm = 20'(word[21:10]);
        issue_and_check(word, 1'b1, exp, '0);
    endtask

    task automatic alu_imm_case(input logic [9:0] opc, input decode_pkg::alu_op_t op);
        decode_pkg::reg_idx_t rd;
        decode_pkg::reg_idx_t rj;
        logic [11:0]          imm12;
        decode_pkg::uop_t     exp;
        rd    = rand_reg();
        rj    = rand_reg();
        imm12 = 12'($random(seed));
        exp   = reg3_uop(rd, rj, '0, 1'b0);
        exp.iq_sel       = decode_pkg::IQ_ALU;
        exp.exec.alu_op  = op;
        exp.exec.alu_imm = 20'(imm12);
        issue_and_check({opc, imm12, rj, rd}, 1'b1, exp, '0);
    endtask

    task automatic muldiv_case(input logic [16:0] opc, input decode_pkg::muldiv_op_t op);
        decode_pkg::reg_idx_t rd;
        decode_pkg::reg_idx_t rj;
        decode_pkg::reg_idx_t rk;
        decode_pkg::uop_t     exp;
        rd  = rand_reg();
        rj  = rand_reg();
        rk  = rand_reg();
        exp = reg3_uop(rd, rj, rk, 1'b1);
        exp.iq_sel         = decode_pkg::IQ_MULDIV;
        exp.exec.muldiv_op = op;
        issue_and_check({opc, rk, rj, rd}, 1'b1, exp, '0);
    endtask

    task automatic branch16_case(input logic [5:0] opc, input decode_pkg::bru_op_t op,
                                 input logic is_jirl);
        decode_pkg::reg_idx_t rd;
        decode_pkg::reg_idx_t rj;
        logic [15:0]          offs16;
        decode_pkg::uop_t     exp;
        rd     = rand_reg();
        rj     = rand_reg();
        offs16 = 16'($random(seed));
        exp    = '0;
        exp.iq_sel             = decode_pkg::IQ_BRU;
        exp.branch.bru_op      = op;
        exp.branch.bru_imm     = 26'(offs16);
        exp.operands.dest_en   = is_jirl;
        exp.operands.dest      = rd;
        exp.operands.src1_en   = 1'b1;
        exp.operands.src1      = rj;
        exp.operands.src2_en   = !is_jirl; // Conditional branches compare rd
        exp.operands.src2      = is_jirl ? '0 : rd;
        issue_and_check({opc, offs16, rj, rd}, 1'b1, exp, '0);
    endtask

    task automatic branch26_case(input logic [5:0] opc, input decode_pkg::bru_op_t op,
                                 input logic links);
        logic [25:0]        offs26;
        decode_pkg::instr_t word;
        decode_pkg::uop_t   exp;
        offs26 = 26'($random(seed));
        word   = {opc, offs26[15:0], offs26[25:16]};
        exp    = '0;
        exp.iq_sel           = decode_pkg::IQ_BRU;
        exp.branch.bru_op    = op;
        exp.branch.bru_imm   = offs26;
        exp.operands.dest_en = links;
        exp.operands.dest    = links ? 5'd1 : word[4:0];
        exp.operands.src1    = word[9:5];
        issue_and_check(word, 1'b1, exp, '0);
    endtask

    task automatic wide_imm_case(input logic [6:0] opc, input logic to_alu);
        decode_pkg::reg_idx_t rd;
        logic [19:0]          imm20;
        decode_pkg::instr_t   word;
        decode_pkg::uop_t     exp;
        rd    = rand_reg();
        imm20 = 20'($random(seed));
        word  = {opc, imm20, rd};
        exp   = '0;
        exp.operands.dest_en = 1'b1;
        exp.operands.dest    = rd;
        exp.operands.src1    = word[9:5];
        if (to_alu) begin
            exp.iq_sel        = decode_pkg::IQ_ALU;
            exp.exec.alu_op   = decode_pkg::ALU_LU12I;
            exp.exec.alu_imm  = imm20;
        end else begin
            exp.iq_sel         = decode_pkg::IQ_BRU;
            exp.branch.bru_op  = decode_pkg::BRU_PCADDU12I;
            exp.branch.bru_imm = 26'(imm20);
        end
        issue_and_check(word, 1'b1, exp, '0);
    endtask

    task automatic alu_tests();
        alu_reg_case(17'h00020, decode_pkg::ALU_ADD, 1'b1);
        alu_reg_case(17'h00022, decode_pkg::ALU_SUB, 1'b1);
        alu_reg_case(17'h00030, decode_pkg::ALU_SRA, 1'b1);
        alu_reg_case(17'h00081, decode_pkg::ALU_SLLI, 1'b0);
        alu_imm_case(10'h00a, decode_pkg::ALU_ADDI);
        alu_imm_case(10'h00e, decode_pkg::ALU_ORI);
        wide_imm_case(7'b0001010, 1'b1); // LU12I.W
    endtask

    task automatic muldiv_tests();
        muldiv_case(17'h00038, decode_pkg::MD_MUL);
        muldiv_case(17'h00039, decode_pkg::MD_MULH);
        muldiv_case(17'h0003a, decode_pkg::MD_MULHU);
        muldiv_case(17'h00040, decode_pkg::MD_DIV);
        muldiv_case(17'h00041, decode_pkg::MD_MOD);
        muldiv_case(17'h00042, decode_pkg::MD_DIVU);
        muldiv_case(17'h00043, decode_pkg::MD_MODU);
    endtask

    task automatic branch_tests();
        wide_imm_case(7'b0001110, 1'b0); // PCADDU12I
        branch16_case(6'h13, decode_pkg::BRU_JIRL, 1'b1);
        branch26_case(6'h14, decode_pkg::BRU_B, 1'b0);
        branch26_case(6'h15, decode_pkg::BRU_BL, 1'b1);
        branch16_case(6'h16, decode_pkg::BRU_BEQ, 1'b0);
        branch16_case(6'h1b, decode_pkg::BRU_BGEU, 1'b0);
    endtask

    task automatic exception_tests();
        decode_pkg::pc_t cur_pc;
        // LD.W is outside the decoded set
        issue_and_check({10'h0a2, 12'h123, rand_reg(), rand_reg()}, 1'b0, '0, 3'b100);
        cur_pc  = pc_next;
        pc_next = pc_next + 32'd4;
        apply(1'b1, {17'h00020, 15'h1234}, cur_pc, 2'b10, 1'b0, 1'b0);
        expect_outputs(1'b0, '0, cur_pc, 3'b010);
    endtask

    task automatic hold_flush_tests();
        decode_pkg::reg_idx_t rd;
        decode_pkg::pc_t      pc_a;
        decode_pkg::pc_t      pc_b;
        decode_pkg::uop_t     exp_a;
        decode_pkg::uop_t     exp_b;
        decode_pkg::instr_t   word_b;
        rd    = rand_reg();
        pc_a  = pc_next;
        pc_b  = pc_next + 32'd4;
        exp_a = reg3_uop(rd, 5'd2, 5'd3, 1'b1);
        exp_a.iq_sel       = decode_pkg::IQ_ALU;
        exp_a.exec.alu_op  = decode_pkg::ALU_ADD;
        exp_a.exec.alu_imm = 20'({7'h20, 5'd3});
        word_b = {17'h00022, 5'd6, 5'd5, 5'd4};
        exp_b  = reg3_uop(5'd4, 5'd5, 5'd6, 1'b1);
        exp_b.iq_sel       = decode_pkg::IQ_ALU;
        exp_b.exec.alu_op  = decode_pkg::ALU_SUB;
        exp_b.exec.alu_imm = 20'({7'h22, 5'd6});
        apply(1'b1, {17'h00020, 5'd3, 5'd2, rd}, pc_a, '0, 1'b0, 1'b0);
        expect_outputs(1'b1, exp_a, pc_a, '0);
        apply(1'b1, word_b, pc_b, '0, 1'b1, 1'b0); // New inputs under hold
        expect_outputs(1'b1, exp_a, pc_a, '0);
        apply(1'b1, word_b, pc_b, '0, 1'b0, 1'b0); // B loads on the edge after hold drops
        expect_outputs(1'b1, exp_b, pc_b, '0);
        apply(1'b1, {17'h00020, 15'h0421}, pc_b + 32'd4, '0, 1'b0, 1'b1);
        expect_outputs(1'b0, '0, pc_b, '0);
        apply(1'b0, '0, pc_b + 32'd8, '0, 1'b0, 1'b0);
        expect_outputs(1'b0, '0, pc_b, '0);
        pc_next = pc_b + 32'd12;
    endtask

    task automatic wait_idle(output logic ready);
        int unsigned cycles;
        ready  = 1'b0;
        cycles = 0;
        while (!ready && cycles < 20) begin
            @(negedge clk);
            ready = rst_n && !decode_vld && (except_stage3 == '0);
            cycles++;
        end
        if (!ready) begin
            timeouts++;
            $display("Timed out waiting for the decode stage to leave reset");
        end
    endtask

    initial begin
        logic        ready;
        int unsigned assert_fails;
        clk           = 1'b0;
        rst_n         = 1'b0;
        flush         = 1'b0;
        hold          = 1'b0;
        instr_vld     = 1'b0;
        instr         = '0;
        pc_stage2     = '0;
        except_stage2 = '0;
        seed          = 32'haf5a;
        errors        = 0;
        checks        = 0;
        timeouts      = 0;
        pc_next       = 32'h1c00_0000;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        wait_idle(ready);
        if (ready) begin
            alu_tests();
            muldiv_tests();
            branch_tests();
            exception_tests();
            hold_flush_tests();
        end
        repeat (2) @(posedge clk);
        assert_fails = decode_top_i.decode_checker_i.assert_failures;
        $display("Checks: %0d  Errors: %0d  Assertion failures: %0d  Timeouts: %0d",
                 checks, errors, assert_fails, timeouts);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/decode_pkg.sv
src/queue_select.sv
src/exec_decode.sv
src/branch_decode.sv
src/operand_decode.sv
src/decode_stage_reg.sv
src/decode_top.sv
verification/decode_checker.sv
verification/decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= decode_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation ended without a pass status"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
